// File: compile.f
source/tpu_pkg.sv
source/pe.sv
source/systolic_array.sv
source/result_writer.sv
source/tpu_ctrl.sv
source/tpu_top.sv
dv/tb_tpu.sv

// File: dv/tb_tpu.sv
`timescale 1ns/1ps

module tb_tpu;

	localparam int MEM_DEPTH = 32;
	localparam logic [31:0] SEED = 32'h4545_fd91;
	localparam int NUM_RUNS = 14;
	localparam int WATCHDOG_CYCLES =
		NUM_RUNS * (tpu_pkg::COMPUTE_LEN + tpu_pkg::ARRAY_SIZE + 10) * 4;
	localparam int OUT_MAX = 32767;
	localparam int OUT_MIN = -32768;

	logic clk = 1'b0;
	logic srstn;
	logic start;

	logic [tpu_pkg::RADDR_WIDTH-1:0] raddr_w0;
	logic [tpu_pkg::RADDR_WIDTH-1:0] raddr_w1;
	logic [tpu_pkg::RADDR_WIDTH-1:0] raddr_d0;
	logic [tpu_pkg::RADDR_WIDTH-1:0] raddr_d1;
	logic [tpu_pkg::SRAM_DATA_WIDTH-1:0] rdata_w0 = '0;
	logic [tpu_pkg::SRAM_DATA_WIDTH-1:0] rdata_w1 = '0;
	logic [tpu_pkg::SRAM_DATA_WIDTH-1:0] rdata_d0 = '0;
	logic [tpu_pkg::SRAM_DATA_WIDTH-1:0] rdata_d1 = '0;
	logic result_we;
	logic [tpu_pkg::WADDR_WIDTH-1:0] result_waddr;
	logic [tpu_pkg::ROW_WIDTH-1:0] result_wdata;
	logic done;

	// operand memories, one cycle read latency
	logic [tpu_pkg::SRAM_DATA_WIDTH-1:0] mem_w0 [0:MEM_DEPTH-1];
	logic [tpu_pkg::SRAM_DATA_WIDTH-1:0] mem_w1 [0:MEM_DEPTH-1];
	logic [tpu_pkg::SRAM_DATA_WIDTH-1:0] mem_d0 [0:MEM_DEPTH-1];
	logic [tpu_pkg::SRAM_DATA_WIDTH-1:0] mem_d1 [0:MEM_DEPTH-1];

	int d_mat [0:tpu_pkg::ARRAY_SIZE-1][0:tpu_pkg::ARRAY_SIZE-1];
	int w_mat [0:tpu_pkg::ARRAY_SIZE-1][0:tpu_pkg::ARRAY_SIZE-1];

	// monitor bookkeeping
	int row_count = 0;
	int rows_total = 0;
	int done_total = 0;
	logic prev_we = 1'b0;

	always #10 clk = ~clk;

	tpu_top u_tpu_top (
		.clk          (clk),
		.srstn        (srstn),
		.start        (start),
		.raddr_w0     (raddr_w0),
		.raddr_w1     (raddr_w1),
		.raddr_d0     (raddr_d0),
		.raddr_d1     (raddr_d1),
		.rdata_w0     (rdata_w0),
		.rdata_w1     (rdata_w1),
		.rdata_d0     (rdata_d0),
		.rdata_d1     (rdata_d1),
		.result_we    (result_we),
		.result_waddr (result_waddr),
		.result_wdata (result_wdata),
		.done         (done)
	);

	always @(posedge clk) begin
		rdata_w0 <= mem_w0[raddr_w0];
		rdata_w1 <= mem_w1[raddr_w1];
		rdata_d0 <= mem_d0[raddr_d0];
		rdata_d1 <= mem_d1[raddr_d1];
	end

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped");
	endtask

	// weight lane j at address t carries W[t-j][j]
	function automatic logic [7:0] weight_lane(input int t, input int j);
		if (t - j >= 0 && t - j < tpu_pkg::ARRAY_SIZE) begin
			return 8'(w_mat[t-j][j]);
		end else begin
			return 8'h00;
		end
	endfunction

	// data lane i at address t carries D[i][t-i]
	function automatic logic [7:0] data_lane(input int t, input int i);
		if (t - i >= 0 && t - i < tpu_pkg::ARRAY_SIZE) begin
			return 8'(d_mat[i][t-i]);
		end else begin
			return 8'h00;
		end
	endfunction

	// skewed images, lane 0 in the top byte
	task automatic load_memories();
		for (int t = 0; t < MEM_DEPTH; t++) begin
			mem_w0[t] = {weight_lane(t, 0), weight_lane(t, 1), weight_lane(t, 2), weight_lane(t, 3)};
			mem_w1[t] = {weight_lane(t, 4), weight_lane(t, 5), weight_lane(t, 6), weight_lane(t, 7)};
			mem_d0[t] = {data_lane(t, 0), data_lane(t, 1), data_lane(t, 2), data_lane(t, 3)};
			mem_d1[t] = {data_lane(t, 4), data_lane(t, 5), data_lane(t, 6), data_lane(t, 7)};
		end
	endtask

	task automatic fill_random(input int low, input int span);
		for (int i = 0; i < tpu_pkg::ARRAY_SIZE; i++) begin
			for (int k = 0; k < tpu_pkg::ARRAY_SIZE; k++) begin
				d_mat[i][k] = low + int'($urandom % span);
				w_mat[i][k] = low + int'($urandom % span);
			end
		end
	endtask

	task automatic fill_const(input int d_val, input int w_val);
		for (int i = 0; i < tpu_pkg::ARRAY_SIZE; i++) begin
			for (int k = 0; k < tpu_pkg::ARRAY_SIZE; k++) begin
				d_mat[i][k] = d_val;
				w_mat[i][k] = w_val;
			end
		end
	endtask

	// exact row of D x W, clipped to 16 bits, column 0 on top
	function automatic logic [tpu_pkg::ROW_WIDTH-1:0] expected_row(input int row);
		logic [tpu_pkg::ROW_WIDTH-1:0] result;
		int sum;
		int clipped;

		result = '0;
		for (int j = 0; j < tpu_pkg::ARRAY_SIZE; j++) begin
			sum = 0;
			for (int k = 0; k < tpu_pkg::ARRAY_SIZE; k++) begin
				sum = sum + d_mat[row][k] * w_mat[k][j];
			end
			if (sum > OUT_MAX) begin
				clipped = OUT_MAX;
			end else if (sum < OUT_MIN) begin
				clipped = OUT_MIN;
			end else begin
				clipped = sum;
			end
			result[(tpu_pkg::ARRAY_SIZE-1-j)*tpu_pkg::OUT_WIDTH +: tpu_pkg::OUT_WIDTH] =
				16'(clipped);
		end
		return result;
	endfunction

	task automatic check_raddr(input string name,
			input logic [tpu_pkg::RADDR_WIDTH-1:0] got,
			input logic [tpu_pkg::RADDR_WIDTH-1:0] exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_waddr(input logic [tpu_pkg::WADDR_WIDTH-1:0] got,
			input logic [tpu_pkg::WADDR_WIDTH-1:0] exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("Fail result_waddr: got 0x%h, expected 0x%h", got, exp));
		end
	endtask

	task automatic check_row(input logic [tpu_pkg::ROW_WIDTH-1:0] got,
			input logic [tpu_pkg::ROW_WIDTH-1:0] exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("Fail result_wdata: got 0x%h, expected 0x%h", got, exp));
		end
	endtask

	task automatic check_done(input int rows_seen, input logic we_before);
		if (rows_seen != tpu_pkg::ARRAY_SIZE || !we_before) begin
			stop_with_failure($sformatf("done did not follow the eighth row (%0d rows seen)",
				rows_seen));
		end
	endtask

	// compares every written row against the reference
	always @(posedge clk) begin
		if (srstn) begin
			if (result_we) begin
				if (row_count >= tpu_pkg::ARRAY_SIZE) begin
					stop_with_failure("an extra result row was written after the eighth");
				end else begin
					check_waddr(result_waddr, tpu_pkg::WADDR_WIDTH'(row_count));
					check_row(result_wdata, expected_row(row_count));
					row_count = row_count + 1;
					rows_total = rows_total + 1;
				end
			end else begin
				// write port rests at zero between rows
				check_waddr(result_waddr, '0);
				check_row(result_wdata, '0);
			end
			if (done) begin
				check_done(row_count, prev_we);
				row_count = 0;
				done_total = done_total + 1;
			end
			prev_we = result_we;
		end
	end

	task automatic run_once(input logic restart_in_feed);
		@(negedge clk);
		load_memories();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		if (restart_in_feed) begin
			// this pulse lands while the feed phase is running
			repeat (6) @(posedge clk);
			start <= 1'b1;
			@(posedge clk);
			start <= 1'b0;
		end
		do begin
			@(posedge clk);
		end while (!done);
	endtask

	initial begin
		int rows_before;
		int done_before;

		void'($urandom(SEED));
		srstn = 1'b0;
		start = 1'b0;
		fill_const(0, 0);
		load_memories();
		repeat (5) @(posedge clk);
		srstn <= 1'b1;

		// quiet outputs before any start
		repeat (10) begin
			@(posedge clk);
			if (result_we !== 1'b0 || done !== 1'b0) begin
				stop_with_failure("result_we or done went high before any start");
			end
			check_raddr("raddr_w0", raddr_w0, '0);
			check_raddr("raddr_w1", raddr_w1, '0);
			check_raddr("raddr_d0", raddr_d0, '0);
			check_raddr("raddr_d1", raddr_d1, '0);
		end

		fill_random(-8, 16);
		run_once(1'b0);

		// saturation in both directions
		fill_const(127, 127);
		run_once(1'b0);
		fill_const(-128, 127);
		run_once(1'b0);

		// back to back, sums must start from zero each time
		repeat (10) begin
			fill_random(-128, 256);
			run_once(1'b0);
		end

		fill_random(-128, 256);
		run_once(1'b1);
		@(negedge clk);
		rows_before = rows_total;
		done_before = done_total;
		repeat (tpu_pkg::COMPUTE_LEN + tpu_pkg::ARRAY_SIZE + 4) @(posedge clk);
		@(negedge clk);
		if (rows_total != rows_before || done_total != done_before) begin
			stop_with_failure("a start during the feed phase launched another run");
		end

		if (done_total == NUM_RUNS && rows_total == NUM_RUNS * tpu_pkg::ARRAY_SIZE) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			stop_with_failure($sformatf("expected %0d runs but saw %0d done pulses",
				NUM_RUNS, done_total));
		end
	end

	// watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		stop_with_failure("timeout: the DUT did not finish all runs in time");
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# build the tpu testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

TOP=tb_tpu
BUILD_DIR=obj_dir
LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
	--top-module "$TOP" --Mdir "$BUILD_DIR" -f compile.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
	echo "simulation reported failure, see $LOG"
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi
exit 0

// File: source/pe.sv
`timescale 1ns/1ps

module pe (
	input  logic clk,
	input  logic srstn,
	input  logic clear_acc,
	input  logic shift_en,
	input  logic signed [tpu_pkg::DATA_WIDTH-1:0] weight_in,
	input  logic signed [tpu_pkg::DATA_WIDTH-1:0] data_in,
	output logic signed [tpu_pkg::DATA_WIDTH-1:0] weight_out,
	output logic signed [tpu_pkg::DATA_WIDTH-1:0] data_out,
	output logic signed [tpu_pkg::ACC_WIDTH-1:0] acc
);

	logic signed [2*tpu_pkg::DATA_WIDTH-1:0] product;
	logic signed [tpu_pkg::ACC_WIDTH-1:0] product_ext;

	assign product = weight_in * data_in;

	// sign extend into the guard bits
	assign product_ext = {{(tpu_pkg::ACC_WIDTH - 2 * tpu_pkg::DATA_WIDTH)
		{product[2*tpu_pkg::DATA_WIDTH-1]}}, product};

	always_ff @(posedge clk) begin
		if (!srstn) begin
			weight_out <= '0;
			data_out <= '0;
			acc <= '0;
		end else begin
			if (clear_acc) begin
				acc <= '0;
			end else if (shift_en) begin
				acc <= acc + product_ext;
			end
			// pass operands on to the neighbours
			if (shift_en) begin
				weight_out <= weight_in;
				data_out <= data_in;
			end
		end
	end

endmodule

// File: source/result_writer.sv
`timescale 1ns/1ps

module result_writer (
	input  logic clk,
	input  logic srstn,
	input  logic row_valid,
	input  logic [tpu_pkg::WADDR_WIDTH-1:0] row_sel,
	input  logic [tpu_pkg::ARRAY_SIZE*tpu_pkg::ACC_WIDTH-1:0] row_acc,
	output logic result_we,
	output logic [tpu_pkg::WADDR_WIDTH-1:0] result_waddr,
	output logic [tpu_pkg::ROW_WIDTH-1:0] result_wdata
);

	logic [tpu_pkg::ROW_WIDTH-1:0] packed_row;

	// clip to signed 16 bits
	function automatic logic [tpu_pkg::OUT_WIDTH-1:0] saturate(
		input logic signed [tpu_pkg::ACC_WIDTH-1:0] value
	);
		logic signed [tpu_pkg::ACC_WIDTH-1:0] clipped;

		clipped = value;
		if (value >= tpu_pkg::SAT_MAX) begin
			clipped = tpu_pkg::SAT_MAX;
		end else if (value <= tpu_pkg::SAT_MIN) begin
			clipped = tpu_pkg::SAT_MIN;
		end
		return clipped[tpu_pkg::OUT_WIDTH-1:0];
	endfunction

	// column 0 goes to the top 16 bits
	always_comb begin
		for (int j = 0; j < tpu_pkg::ARRAY_SIZE; j++) begin
			packed_row[(tpu_pkg::ARRAY_SIZE-1-j)*tpu_pkg::OUT_WIDTH +: tpu_pkg::OUT_WIDTH] =
				saturate($signed(row_acc[j*tpu_pkg::ACC_WIDTH +: tpu_pkg::ACC_WIDTH]));
		end
	end

	always_ff @(posedge clk) begin
		if (!srstn) begin
			result_we <= 1'b0;
		end else begin
			result_we <= row_valid;
		end
	end

	// address and data follow the enable, zero between writes
	always_ff @(posedge clk) begin
		if (row_valid) begin
			result_waddr <= row_sel;
			result_wdata <= packed_row;
		end else begin
			result_waddr <= '0;
			result_wdata <= '0;
		end
	end

	a_waddr_known: assert property (@(posedge clk) disable iff (!srstn)
		result_we |-> !$isunknown(result_waddr));

endmodule

// File: source/systolic_array.sv
`timescale 1ns/1ps

module systolic_array (
	input  logic clk,
	input  logic srstn,
	input  logic clear_acc,
	input  logic shift_en,
	input  logic [tpu_pkg::SRAM_DATA_WIDTH-1:0] rdata_w0,
	input  logic [tpu_pkg::SRAM_DATA_WIDTH-1:0] rdata_w1,
	input  logic [tpu_pkg::SRAM_DATA_WIDTH-1:0] rdata_d0,
	input  logic [tpu_pkg::SRAM_DATA_WIDTH-1:0] rdata_d1,
	input  logic [tpu_pkg::WADDR_WIDTH-1:0] row_sel,
	output logic [tpu_pkg::ARRAY_SIZE*tpu_pkg::ACC_WIDTH-1:0] row_acc
);

	// w_bus[i][j] feeds pe (i, j) from above, d_bus[i][j] from the left
	// the extra row and column catch what falls off the grid edge
	logic signed [tpu_pkg::DATA_WIDTH-1:0] w_bus [0:tpu_pkg::ARRAY_SIZE][0:tpu_pkg::ARRAY_SIZE-1];
	logic signed [tpu_pkg::DATA_WIDTH-1:0] d_bus [0:tpu_pkg::ARRAY_SIZE-1][0:tpu_pkg::ARRAY_SIZE];
	logic signed [tpu_pkg::ACC_WIDTH-1:0] acc_grid [0:tpu_pkg::ARRAY_SIZE-1][0:tpu_pkg::ARRAY_SIZE-1];

	// lane 0 sits in the top byte of each word
	for (genvar l = 0; l < tpu_pkg::LANES_PER_WORD; l++) begin : g_lane
		localparam int HI = tpu_pkg::SRAM_DATA_WIDTH - 1 - l * tpu_pkg::DATA_WIDTH;

		assign w_bus[0][l] = rdata_w0[HI -: tpu_pkg::DATA_WIDTH];
		assign w_bus[0][l + tpu_pkg::LANES_PER_WORD] = rdata_w1[HI -: tpu_pkg::DATA_WIDTH];
		assign d_bus[l][0] = rdata_d0[HI -: tpu_pkg::DATA_WIDTH];
		assign d_bus[l + tpu_pkg::LANES_PER_WORD][0] = rdata_d1[HI -: tpu_pkg::DATA_WIDTH];
	end

	// weights move down, data moves right
	for (genvar i = 0; i < tpu_pkg::ARRAY_SIZE; i++) begin : g_row
		for (genvar j = 0; j < tpu_pkg::ARRAY_SIZE; j++) begin : g_col
			pe u_pe (
				.clk        (clk),
				.srstn      (srstn),
				.clear_acc  (clear_acc),
				.shift_en   (shift_en),
				.weight_in  (w_bus[i][j]),
				.data_in    (d_bus[i][j]),
				.weight_out (w_bus[i+1][j]),
				.data_out   (d_bus[i][j+1]),
				.acc        (acc_grid[i][j])
			);
		end
	end

	// row readout, column 0 in the low bits
	always_comb begin
		for (int j = 0; j < tpu_pkg::ARRAY_SIZE; j++) begin
			row_acc[j*tpu_pkg::ACC_WIDTH +: tpu_pkg::ACC_WIDTH] = acc_grid[row_sel][j];
		end
	end

	// a clear must never race a shift
	a_clear_vs_shift: assert property (@(posedge clk) disable iff (!srstn)
		!(clear_acc && shift_en));

endmodule

// File: source/tpu_ctrl.sv
`timescale 1ns/1ps

module tpu_ctrl (
	input  logic clk,
	input  logic srstn,
	input  logic start,
	output logic [tpu_pkg::RADDR_WIDTH-1:0] raddr,
	output logic clear_acc,
	output logic shift_en,
	output logic row_valid,
	output logic [tpu_pkg::WADDR_WIDTH-1:0] row_sel,
	output logic done
);

	logic [1:0] state;
	logic last_row;

	// start only counts in idle; clear the sums on that same edge
	assign clear_acc = (state == tpu_pkg::ST_IDLE) && start;

	// first drain cycle still carries the final shift
	assign row_valid = (state == tpu_pkg::ST_DRAIN) && !shift_en;

	// phase and address counter
	always_ff @(posedge clk) begin
		if (!srstn) begin
			state <= tpu_pkg::ST_IDLE;
			raddr <= '0;
		end else begin
			case (state)
				tpu_pkg::ST_IDLE: begin
					if (start) begin
						state <= tpu_pkg::ST_FEED;
					end
				end
				tpu_pkg::ST_FEED: begin
					if (raddr == tpu_pkg::LAST_RADDR) begin
						state <= tpu_pkg::ST_DRAIN;
						raddr <= '0;
					end else begin
						raddr <= raddr + 1'b1;
					end
				end
				tpu_pkg::ST_DRAIN: begin
					if (row_valid && row_sel == tpu_pkg::LAST_ROW) begin
						state <= tpu_pkg::ST_IDLE;
					end
				end
				default: begin
					state <= tpu_pkg::ST_IDLE;
				end
			endcase
		end
	end

	// shift one cycle behind the address, matching the read latency
	always_ff @(posedge clk) begin
		if (!srstn) begin
			shift_en <= 1'b0;
		end else begin
			shift_en <= (state == tpu_pkg::ST_FEED);
		end
	end

	// row counter for readout
	always_ff @(posedge clk) begin
		if (!srstn) begin
			row_sel <= '0;
		end else if (row_valid) begin
			if (row_sel == tpu_pkg::LAST_ROW) begin
				row_sel <= '0;
			end else begin
				row_sel <= row_sel + 1'b1;
			end
		end
	end

	// done lands one cycle after the writer registers the last row
	always_ff @(posedge clk) begin
		if (!srstn) begin
			last_row <= 1'b0;
			done <= 1'b0;
		end else begin
			last_row <= row_valid && (row_sel == tpu_pkg::LAST_ROW);
			done <= last_row;
		end
	end

	// one done per run
	a_done_pulse: assert property (@(posedge clk) disable iff (!srstn)
		done |=> !done);

	// readout starts right after the last shift has landed
	a_drain_start: assert property (@(posedge clk) disable iff (!srstn)
		$fell(shift_en) |-> row_valid);

	// every readout begins at row 0
	a_row_start: assert property (@(posedge clk) disable iff (!srstn)
		$rose(row_valid) |-> (row_sel == '0));

endmodule

// File: source/tpu_pkg.sv
package tpu_pkg;

	// grid and operand sizes
	localparam int ARRAY_SIZE = 8;
	localparam int DATA_WIDTH = 8;
	localparam int LANES_PER_WORD = 4;
	localparam int SRAM_DATA_WIDTH = 32;

	// two operand widths plus guard bits for the 8-term sum
	localparam int ACC_WIDTH = 2 * DATA_WIDTH + 5;
	localparam int OUT_WIDTH = 16;
	localparam int ROW_WIDTH = ARRAY_SIZE * OUT_WIDTH;

	localparam int RADDR_WIDTH = 5;
	localparam int WADDR_WIDTH = 3;

	// skewed words per port, and addresses issued per run
	localparam int FEED_LEN = 2 * ARRAY_SIZE - 1;
	localparam int COMPUTE_LEN = 3 * ARRAY_SIZE - 2;

	localparam logic [RADDR_WIDTH-1:0] LAST_RADDR = RADDR_WIDTH'(COMPUTE_LEN - 1);
	localparam logic [WADDR_WIDTH-1:0] LAST_ROW = WADDR_WIDTH'(ARRAY_SIZE - 1);

	// saturation bounds at accumulator width
	localparam logic signed [ACC_WIDTH-1:0] SAT_MAX = 32767;
	localparam logic signed [ACC_WIDTH-1:0] SAT_MIN = -32768;

	// controller phases
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_FEED = 2'd1;
	localparam logic [1:0] ST_DRAIN = 2'd2;

endpackage

// File: source/tpu_top.sv
`timescale 1ns/1ps

module tpu_top (
	input  logic clk,
	input  logic srstn,
	input  logic start,

	// read addresses, one per memory
	output logic [tpu_pkg::RADDR_WIDTH-1:0] raddr_w0,
	output logic [tpu_pkg::RADDR_WIDTH-1:0] raddr_w1,
	output logic [tpu_pkg::RADDR_WIDTH-1:0] raddr_d0,
	output logic [tpu_pkg::RADDR_WIDTH-1:0] raddr_d1,

	// skewed operand words
	input  logic [tpu_pkg::SRAM_DATA_WIDTH-1:0] rdata_w0,
	input  logic [tpu_pkg::SRAM_DATA_WIDTH-1:0] rdata_w1,
	input  logic [tpu_pkg::SRAM_DATA_WIDTH-1:0] rdata_d0,
	input  logic [tpu_pkg::SRAM_DATA_WIDTH-1:0] rdata_d1,

	// result write port
	output logic result_we,
	output logic [tpu_pkg::WADDR_WIDTH-1:0] result_waddr,
	output logic [tpu_pkg::ROW_WIDTH-1:0] result_wdata,

	output logic done
);

	logic [tpu_pkg::RADDR_WIDTH-1:0] raddr;
	logic clear_acc;
	logic shift_en;
	logic row_valid;
	logic [tpu_pkg::WADDR_WIDTH-1:0] row_sel;
	logic [tpu_pkg::ARRAY_SIZE*tpu_pkg::ACC_WIDTH-1:0] row_acc;

	// all four memories walk the same skewed address
	assign raddr_w0 = raddr;
	assign raddr_w1 = raddr;
	assign raddr_d0 = raddr;
	assign raddr_d1 = raddr;

	tpu_ctrl u_ctrl (
		.clk       (clk),
		.srstn     (srstn),
		.start     (start),
		.raddr     (raddr),
		.clear_acc (clear_acc),
		.shift_en  (shift_en),
		.row_valid (row_valid),
		.row_sel   (row_sel),
		.done      (done)
	);

	systolic_array u_array (
		.clk       (clk),
		.srstn     (srstn),
		.clear_acc (clear_acc),
		.shift_en  (shift_en),
		.rdata_w0  (rdata_w0),
		.rdata_w1  (rdata_w1),
		.rdata_d0  (rdata_d0),
		.rdata_d1  (rdata_d1),
		.row_sel   (row_sel),
		.row_acc   (row_acc)
	);

	result_writer u_writer (
		.clk          (clk),
		.srstn        (srstn),
		.row_valid    (row_valid),
		.row_sel      (row_sel),
		.row_acc      (row_acc),
		.result_we    (result_we),
		.result_waddr (result_waddr),
		.result_wdata (result_wdata)
	);

endmodule
